// ==== src/rv_isa_pkg.sv ====
// rv32i subset ISA definitions: instruction word views, opcodes and funct codes
`default_nettype none

package rv_isa_pkg;

    // register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // immediate and shift format
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // upper immediate format
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    // branch format, immediate scattered across the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        u_view_t u_view;
        b_view_t b_view;
    } instr_t;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // funct7 of sub, add uses all zeros
    localparam logic [6:0] f7_sub = 7'b0100000;

endpackage : rv_isa_pkg

`default_nettype wire

// ==== src/rv_ctrl_pkg.sv ====
// datapath control types: ALU operation codes and immediate format selector
`default_nettype none

package rv_ctrl_pkg;

    // ALU operations, LUI passes operand b through
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        OR  = 3'd2,
        SLL = 3'd3,
        SRL = 3'd4,
        LUI = 3'd5
    } alu_op_t;

    // which immediate layout the extender builds
    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_U = 2'd1,
        IMM_B = 2'd2
    } imm_sel_t;

endpackage : rv_ctrl_pkg

`default_nettype wire

// ==== src/ctrl_if.sv ====
// control bundle carrying decoded instruction controls to the datapath
`default_nettype none
`timescale 1ns/1ps

interface ctrl_if;
    import rv_ctrl_pkg::*;

    // operand b from rs2 instead of the immediate
    logic     src_b_reg;
    logic     branch;
    // branch on not equal
    logic     bne;
    logic     reg_we;
    imm_sel_t imm_sel;
    alu_op_t  alu_op;

    modport decoder (
        output src_b_reg, branch, bne, reg_we, imm_sel, alu_op
    );

    modport datapath (
        input src_b_reg, branch, bne, reg_we, imm_sel, alu_op
    );

endinterface : ctrl_if

`default_nettype wire

// ==== src/control_unit.sv ====
// control unit: decodes opcode, funct3 and funct7 into datapath controls
`default_nettype none
`timescale 1ns/1ps

module control_unit (
    input   rv_isa_pkg::instr_t instr,
    ctrl_if.decoder             ctrl
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr.r_view.opcode;
    assign funct3 = instr.r_view.funct3;
    assign funct7 = instr.r_view.funct7;

    always_comb begin
        // anything not matched below behaves as a no-op
        ctrl.src_b_reg = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.bne       = 1'b0;
        ctrl.reg_we    = 1'b0;
        ctrl.imm_sel   = IMM_I;
        ctrl.alu_op    = ADD;

        case (opcode)
            op_lui: begin
                ctrl.imm_sel = IMM_U;
                ctrl.alu_op  = LUI;
                ctrl.reg_we  = 1'b1;
            end
            op_imm: begin
                ctrl.imm_sel = IMM_I;
                case (funct3)
                    f3_add: begin
                        ctrl.alu_op = ADD;
                        ctrl.reg_we = 1'b1;
                    end
                    f3_or: begin
                        ctrl.alu_op = OR;
                        ctrl.reg_we = 1'b1;
                    end
                    // srai shares f3_srl, only the logical form is kept
                    f3_sll: begin
                        ctrl.alu_op = SLL;
                        ctrl.reg_we = (funct7 == 7'b0000000);
                    end
                    f3_srl: begin
                        ctrl.alu_op = SRL;
                        ctrl.reg_we = (funct7 == 7'b0000000);
                    end
                    default: ctrl.reg_we = 1'b0;
                endcase
            end
            op_reg: begin
                ctrl.src_b_reg = 1'b1;
                if (funct3 == f3_add && funct7 == f7_sub) begin
                    ctrl.alu_op = SUB;
                    ctrl.reg_we = 1'b1;
                end else if (funct3 == f3_add && funct7 == 7'b0000000) begin
                    ctrl.alu_op = ADD;
                    ctrl.reg_we = 1'b1;
                end else if (funct3 == f3_or && funct7 == 7'b0000000) begin
                    ctrl.alu_op = OR;
                    ctrl.reg_we = 1'b1;
                end
            end
            op_branch: begin
                // compare by subtraction, zero flag decides
                ctrl.src_b_reg = 1'b1;
                ctrl.imm_sel   = IMM_B;
                ctrl.alu_op    = SUB;
                ctrl.branch    = (funct3 == f3_beq) || (funct3 == f3_bne);
                ctrl.bne       = (funct3 == f3_bne);
            end
            default: ;
        endcase
    end

endmodule : control_unit

`default_nettype wire

// ==== src/imm_gen.sv ====
// immediate generator: sign-extends I and B immediates, places U in the upper bits
`default_nettype none
`timescale 1ns/1ps

module imm_gen (
    input   logic   [11:0]      imm_i,
    input   logic   [19:0]      imm_u,
    input   logic   [11:0]      imm_b,
    ctrl_if.datapath            ctrl,
    output  logic   [31:0]      imm_ext
);
    import rv_ctrl_pkg::*;

    always_comb begin
        case (ctrl.imm_sel)
            IMM_I: begin
                imm_ext = {{20{imm_i[11]}}, imm_i};
            end
            IMM_U: begin
                imm_ext = {imm_u, 12'h000};
            end
            // still in halfword units here
            IMM_B: begin
                imm_ext = {{20{imm_b[11]}}, imm_b};
            end
            default: begin
                imm_ext = '0;
            end
        endcase
    end

endmodule : imm_gen

`default_nettype wire

// ==== src/reg_file.sv ====
// register file: 32 x 32 bits, two read ports, a debug read port and one write port
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input   logic               clk,
    input   logic   [4:0]       ra1,
    output  logic   [31:0]      rd1,
    input   logic   [4:0]       ra2,
    output  logic   [31:0]      rd2,
    input   logic   [4:0]       wa,
    input   logic   [31:0]      wd,
    input   logic               we,
    input   logic   [4:0]       dbg_addr,
    output  logic   [31:0]      dbg_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // asynchronous reads, address zero forced to zero
    assign rd1      = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
    assign rd2      = (ra2 == 5'd0) ? 32'h0 : regs[ra2];
    assign dbg_data = (dbg_addr == 5'd0) ? 32'h0 : regs[dbg_addr];

endmodule : reg_file

`default_nettype wire

// ==== src/alu.sv ====
// ALU: add, sub, or, logical shifts and operand b pass-through, with zero flag
`default_nettype none
`timescale 1ns/1ps

module alu (
    input   logic   [31:0]      src_a,
    input   logic   [31:0]      src_b,
    input   logic   [4:0]       shamt,
    ctrl_if.datapath            ctrl,
    output  logic   [31:0]      result,
    output  logic               zero
);
    import rv_ctrl_pkg::*;

    always_comb begin
        case (ctrl.alu_op)
            ADD:     result = src_a + src_b;
            SUB:     result = src_a - src_b;
            OR:      result = src_a | src_b;
            // shift amount comes straight from the instruction
            SLL:     result = src_a << shamt;
            SRL:     result = src_a >> shamt;
            LUI:     result = src_b;
            default: result = '0;
        endcase
    end

    // used for beq/bne after a SUB
    assign zero = (result == 32'h0);

endmodule : alu

`default_nettype wire

// ==== src/rv_core.sv ====
// rv32i subset core: program counter, next-PC and branch logic around the datapath units
`default_nettype none
`timescale 1ns/1ps

module rv_core #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input   logic               clk,
    input   logic               rst_n,
    input   logic               cpu_en,
    output  logic   [31:0]      instr_addr,
    input   logic   [31:0]      instr,
    input   logic   [4:0]       reg_addr,
    output  logic   [31:0]      reg_data
);
    import rv_isa_pkg::*;

    instr_t      instr_w;
    // register file
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [4:0]  wa;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic        rf_we;
    // immediates
    logic [11:0] imm_i;
    logic [19:0] imm_u;
    logic [11:0] imm_b;
    logic [31:0] imm_ext;
    // ALU
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [4:0]  shamt;
    logic [31:0] result;
    logic        zero;
    // next pc
    logic [31:0] pc_plus4;
    logic [31:0] pc_branch;
    logic        take_branch;
    logic [31:0] pc_next;

    ctrl_if ctrl ();

    assign instr_w = instr;

    // field extraction through the union views
    assign ra1   = instr_w.r_view.rs1;
    assign ra2   = instr_w.r_view.rs2;
    assign wa    = instr_w.r_view.rd;
    assign shamt = instr_w.i_view.imm12[4:0];
    assign imm_i = instr_w.i_view.imm12;
    assign imm_u = instr_w.u_view.imm20;
    assign imm_b = {instr_w.b_view.imm_12, instr_w.b_view.imm_11,
                    instr_w.b_view.imm_10_5, instr_w.b_view.imm_4_1};

    assign src_a = rd1;
    assign src_b = ctrl.src_b_reg ? rd2 : imm_ext;

    // no writes while stalled or in reset
    assign rf_we = ctrl.reg_we && cpu_en && rst_n;

    // B immediate is halfword-scaled
    assign pc_plus4    = instr_addr + 32'd4;
    assign pc_branch   = instr_addr + (imm_ext << 1);
    assign take_branch = ctrl.branch && (zero != ctrl.bne);
    assign pc_next     = take_branch ? pc_branch : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_addr <= reset_pc;
        end else if (cpu_en) begin
            instr_addr <= pc_next;
        end
    end

    control_unit control_unit_inst (
        .instr      (instr_w),
        .ctrl       (ctrl)
    );

    imm_gen imm_gen_inst (
        .imm_i      (imm_i),
        .imm_u      (imm_u),
        .imm_b      (imm_b),
        .ctrl       (ctrl),
        .imm_ext    (imm_ext)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .ra1        (ra1),
        .rd1        (rd1),
        .ra2        (ra2),
        .rd2        (rd2),
        .wa         (wa),
        .wd         (result),
        .we         (rf_we),
        .dbg_addr   (reg_addr),
        .dbg_data   (reg_data)
    );

    alu alu_inst (
        .src_a      (src_a),
        .src_b      (src_b),
        .shamt      (shamt),
        .ctrl       (ctrl),
        .result     (result),
        .zero       (zero)
    );

endmodule : rv_core

`default_nettype wire

// ==== verif/rv_core_checker.sv ====
// core checker: concurrent assertions on PC sequencing and x0 reads, bound into rv_core
`default_nettype none
`timescale 1ns/1ps

module rv_core_checker #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input   logic               clk,
    input   logic               rst_n,
    input   logic               cpu_en,
    input   logic   [31:0]      pc,
    input   logic   [31:0]      instr,
    input   logic   [4:0]       reg_addr,
    input   logic   [31:0]      reg_data
);
    import rv_isa_pkg::*;

    // failed assertions so far
    int unsigned fail_count = 0;
    // B-format byte offset rebuilt from the raw word
    logic [31:0] b_offset;

    assign b_offset = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    a_reset_pc: assert property (@(posedge clk) !rst_n |=> pc == reset_pc)
        else begin
            $error("PC not at the reset vector after reset");
            fail_count = fail_count + 1;
        end

    a_stall_hold: assert property (@(posedge clk) rst_n && !cpu_en |=> $stable(pc))
        else begin
            $error("PC moved while cpu_en was low");
            fail_count = fail_count + 1;
        end

    a_x0_zero: assert property (@(posedge clk) reg_addr == 5'd0 |-> reg_data == 32'h0)
        else begin
            $error("register x0 read nonzero");
            fail_count = fail_count + 1;
        end

    // sequential fetch, or the target of a branch instruction
    a_pc_step: assert property (@(posedge clk) rst_n && cpu_en |=>
            (pc == $past(pc) + 32'd4) ||
            ($past(instr[6:0]) == op_branch && pc == $past(pc) + $past(b_offset)))
        else begin
            $error("PC step was neither +4 nor the branch target");
            fail_count = fail_count + 1;
        end

endmodule : rv_core_checker

bind rv_core rv_core_checker #(.reset_pc(reset_pc)) rv_core_checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_en     (cpu_en),
    .pc         (instr_addr),
    .instr      (instr),
    .reg_addr   (reg_addr),
    .reg_data   (reg_data)
);

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
// core testbench: instruction memory, reference model and directed and random program tests
`default_nettype none
`timescale 1ns/1ps

module rv_core_tb;
    import rv_isa_pkg::*;

    localparam logic [31:0] reset_pc = 32'h0000_0040;
    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    // instruction steps plus register sweeps, rounded up
    localparam int test_cycles  = 320;
    localparam int timeout_ns   = test_cycles * clk_period * 2 + reset_cycles * clk_period;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cpu_en;
    logic [31:0] instr_addr;
    logic [31:0] instr;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;

    logic [31:0] imem [0:63];
    logic [31:0] model_regs [0:31];
    // DUT registers are not reset, only written ones are compared
    bit          known [0:31];
    logic [31:0] model_pc;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    int          stall_cycles;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    rv_core #(.reset_pc(reset_pc)) rv_core_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_en     (cpu_en),
        .instr_addr (instr_addr),
        .instr      (instr),
        .reg_addr   (reg_addr),
        .reg_data   (reg_data)
    );

    // word addressed instruction memory
    assign instr = imem[instr_addr[7:2]];

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    // byte offset, bit 0 dropped by the format
    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    // ISA rules applied to the shadow registers and PC
    task automatic model_exec(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] boff;
        logic [31:0] res;
        logic        wr;
        logic        taken;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};
        boff  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        res   = 32'h0;
        wr    = 1'b1;
        taken = 1'b0;
        case (w[6:0])
            op_lui: res = {w[31:12], 12'h000};
            op_imm: begin
                case (w[14:12])
                    f3_add:  res = a + imm;
                    f3_or:   res = a | imm;
                    f3_sll:  res = a << w[24:20];
                    f3_srl:  res = a >> w[24:20];
                    default: wr = 1'b0;
                endcase
            end
            op_reg: begin
                if (w[14:12] == f3_add && w[31:25] == f7_sub) begin
                    res = a - b;
                end else if (w[14:12] == f3_add) begin
                    res = a + b;
                end else begin
                    res = a | b;
                end
            end
            op_branch: begin
                wr    = 1'b0;
                taken = (w[14:12] == f3_beq) ? (a == b) : (a != b);
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            model_regs[w[11:7]] = res;
            known[w[11:7]]      = 1'b1;
        end
        model_pc = taken ? model_pc + boff : model_pc + 32'd4;
    endtask

    task automatic check_pc();
        assert (instr_addr == model_pc) else begin
            $display("** Error at %0t ns: instr_addr %08h, expected %08h",
                     $time, instr_addr, model_pc);
            test_errors++;
        end
    endtask

    task automatic check_reg(input logic [4:0] idx);
        @(posedge clk);
        reg_addr <= idx;
        @(negedge clk);
        assert (reg_data == model_regs[idx]) else begin
            $display("** Error at %0t ns: x%0d reads %08h, expected %08h",
                     $time, idx, reg_data, model_regs[idx]);
            test_errors++;
        end
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 32; i++) begin
            if (known[i]) begin
                check_reg(i[4:0]);
            end
        end
    endtask

    // one enable pulse, exactly one instruction retires
    task automatic step_at_pc();
        model_exec(imem[model_pc[7:2]]);
        @(posedge clk);
        cpu_en <= 1'b1;
        @(posedge clk);
        cpu_en <= 1'b0;
        @(negedge clk);
        check_pc();
    endtask

    task automatic emit(input logic [31:0] w);
        imem[model_pc[7:2]] = w;
        step_at_pc();
    endtask

    task automatic branch_case(input logic [31:0] br, input logic [4:0] marker_rd);
        logic [31:0] pc0;
        pc0 = model_pc;
        imem[pc0[7:2]] = br;
        // sits in the slot a taken branch skips
        imem[pc0[7:2] + 6'd1] = enc_i(12'h5a5, 5'd0, f3_add, marker_rd);
        step_at_pc();
        if (model_pc == pc0 + 32'd4) begin
            step_at_pc();
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("[%s] ok", name);
        end else begin
            tests_failed++;
            $display("[%s] FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        rst_n        <= 1'b0;
        cpu_en       <= 1'b0;
        reg_addr     <= 5'd0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'h684f983d));
        // nop fill, addi x0, x0, 0
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0000_0013;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
            known[i]      = (i == 0);
        end
        model_pc = reset_pc;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_pc();
        end_test("reset");

        r1 = $urandom();
        r2 = $urandom();
        r3 = $urandom();
        // lui value forced nonzero so x1 and x2 always differ
        emit(enc_u({r1[19:1], 1'b1}, 5'd1));
        emit(enc_i(r2[11:0], 5'd0, f3_add, 5'd2));
        emit(enc_i(r2[23:12], 5'd1, f3_or, 5'd3));
        emit(enc_i({7'b0, r3[4:0]}, 5'd3, f3_sll, 5'd4));
        emit(enc_i({7'b0, r3[9:5]}, 5'd1, f3_srl, 5'd5));
        check_all_regs();
        end_test("imm and lui");

        emit(enc_r(7'b0, 5'd2, 5'd1, f3_add, 5'd6));
        emit(enc_r(f7_sub, 5'd1, 5'd2, f3_add, 5'd7));
        // 0 - x1 wraps around
        emit(enc_r(f7_sub, 5'd1, 5'd0, f3_add, 5'd8));
        emit(enc_r(7'b0, 5'd4, 5'd3, f3_or, 5'd9));
        check_all_regs();
        end_test("reg-reg");

        branch_case(enc_b(13'd8, 5'd1, 5'd1, f3_beq), 5'd6);
        branch_case(enc_b(13'd8, 5'd2, 5'd1, f3_beq), 5'd7);
        branch_case(enc_b(13'd8, 5'd2, 5'd1, f3_bne), 5'd8);
        branch_case(enc_b(13'd8, 5'd1, 5'd1, f3_bne), 5'd9);
        // backward target, offset -8 needs the sign bit
        branch_case(enc_b(13'h1ff8, 5'd1, 5'd1, f3_beq), 5'd6);
        check_all_regs();
        end_test("branch");

        stall_cycles = 3 + ($urandom() % 6);
        imem[model_pc[7:2]] = enc_i(r3[31:20], 5'd1, f3_add, 5'd5);
        repeat (stall_cycles) @(posedge clk);
        @(negedge clk);
        check_pc();
        check_all_regs();
        step_at_pc();
        emit(enc_r(7'b0, 5'd1, 5'd5, f3_add, 5'd10));
        check_all_regs();
        end_test("stall");

        emit(enc_i(r2[31:20], 5'd1, f3_add, 5'd0));
        emit(enc_r(7'b0, 5'd2, 5'd1, f3_add, 5'd0));
        check_all_regs();
        end_test("x0");

        if (rv_core_inst.rv_core_checker_inst.fail_count != 0) begin
            tests_failed++;
            $display("bound core assertions failed %0d times",
                     rv_core_inst.rv_core_checker_inst.fail_count);
        end
        $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the run did not finish", timeout_ns);
        $display("Test failed");
        $finish;
    end

endmodule : rv_core_tb

`default_nettype wire

// ==== filelist.f ====
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/ctrl_if.sv
src/control_unit.sv
src/imm_gen.sv
src/reg_file.sv
src/alu.sv
src/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
SIMFLAGS  = +verilator+error+limit+100
LOG       = sim.log
FAIL_MSG  = Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
